// ==== testbench/jtag_uart_cases.txt ====
// op(1 hex) operand(2 hex) expect(3 hex), one case per line
// op 0 USER1, 1 write, 2 status, 3 flush, 4 scan, 5 short scan, 6 burst, 7 bypass, 8 fill
200001  // status after reset, empty
000000  // select USER1
400000  // scan of an empty FIFO, valid 0
141000  // write 'A'
142000  // write 'B'
143000  // write 'C'
20000c  // three queued
400083  // 'A' with valid
200008  // two queued
504085  // four shifts only, 'B' stays
200008  // still two
400085  // 'B'
400087  // 'C'
200001  // drained
830010  // fill with 0x30 to 0x3f
200042  // full, count 16
15a001  // refused with pslverr
400061  // oldest byte 0x30
20003c  // fifteen left
300000  // flush
200001  // empty again
15a000  // write 'Z'
7a514a  // BYPASS, 0xa5 back one shift late
200004  // bypass scan did not pop
000000  // back to USER1
4000b5  // 'Z'
620000  // random burst of 32 steps
300000  // flush
200001  // empty

// ==== list.f ====
+incdir+rtl
rtl/jtag_uart_pkg.sv
rtl/jtag_tap_controller.sv
rtl/jtag_instruction_register.sv
rtl/shift_bit_counter.sv
rtl/jtag_data_register.sv
rtl/uart_tx_fifo.sv
rtl/apb_uart_regs.sv
rtl/jtag_uart_top.sv
testbench/jtag_uart_tb.sv

// ==== Bender.yml ====
package:
  name: jtag_uart

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/jtag_uart_pkg.sv
      - rtl/jtag_tap_controller.sv
      - rtl/jtag_instruction_register.sv
      - rtl/shift_bit_counter.sv
      - rtl/jtag_data_register.sv
      - rtl/uart_tx_fifo.sv
      - rtl/apb_uart_regs.sv
      - rtl/jtag_uart_top.sv
      - target: test
        files:
          - testbench/jtag_uart_tb.sv

// ==== testbench/jtag_uart_tb.sv ====
// JTAG UART testbench
`timescale 1ns/100ps
`default_nettype none

`include "jtag_uart_defines.svh"

module jtag_uart_tb;
    import jtag_uart_pkg::*;

    localparam int MAX_CASES = 64;
    localparam int SCAN_LEN  = $bits(jtag_scan_t);

    // 1149.1 Capture-IR pattern with 01 in the low bits
    localparam logic [`JTAG_IR_LEN-1:0] IR_CAPTURE = 1;

    // Case opcodes sit in the top nibble of a case word
    localparam logic [3:0] OP_USER1  = 4'h0;
    localparam logic [3:0] OP_WRITE  = 4'h1;
    localparam logic [3:0] OP_STATUS = 4'h2;
    localparam logic [3:0] OP_FLUSH  = 4'h3;
    localparam logic [3:0] OP_SCAN   = 4'h4;
    localparam logic [3:0] OP_SHORT  = 4'h5;
    localparam logic [3:0] OP_BURST  = 4'h6;
    localparam logic [3:0] OP_BYPASS = 4'h7;
    localparam logic [3:0] OP_FILL   = 4'h8;

    logic        tck;
    logic        reset_n;
    logic        tms;
    logic        tdi;
    logic        tdo;
    apb_req_t    apb_req;
    apb_rsp_t    apb_rsp;

    // Each case word holds op, operand byte and expected value
    logic [23:0] cases [MAX_CASES];
    int          n_cases = 0;
    // Reference FIFO contents with the oldest entry first
    logic [7:0]  model_q [$];
    logic        user1_active;
    logic [31:0] rng_state;

    jtag_uart_top jtag_uart_i (
        .tck     (tck),
        .reset_n (reset_n),
        .tms     (tms),
        .tdi     (tdi),
        .tdo     (tdo),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp)
    );

    // 20 ns tck
    initial begin
        tck = 1'b0;
        forever #10 tck = ~tck;
    end

    // ==============================
    // Reference model and checks
    // ==============================

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Fill level as the FIFO should report it
    function automatic uart_status_t model_status();
        uart_status_t s;
        s.count = model_q.size();
        s.full  = (model_q.size() == `TX_FIFO_DEPTH);
        s.empty = (model_q.size() == 0);
        return s;
    endfunction

    // Word a USER1 capture should load
    function automatic jtag_scan_t model_head();
        jtag_scan_t w;
        w = '0;
        if (model_q.size() != 0) begin
            w.data  = model_q[0];
            w.valid = 1'b1;
        end
        return w;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_status(input uart_status_t got, input uart_status_t exp);
        if (got !== exp) begin
            abort_run($sformatf("error at %0t: prdata status got %h expected %h",
                                $time, got, exp));
        end
    endtask

    task automatic check_scan(input jtag_scan_t got, input jtag_scan_t exp);
        if (got !== exp) begin
            abort_run($sformatf("error at %0t: tdo scan word got %h expected %h",
                                $time, got, exp));
        end
    endtask

    task automatic check_slverr(input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("error at %0t: pslverr got %b expected %b",
                                $time, got, exp));
        end
    endtask

    task automatic check_pready(input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("error at %0t: pready got %b expected %b",
                                $time, got, exp));
        end
    endtask

    task automatic check_ir_capture(input logic [`JTAG_IR_LEN-1:0] got,
                                    input logic [`JTAG_IR_LEN-1:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("error at %0t: tdo ir capture got %h expected %h",
                                $time, got, exp));
        end
    endtask

    // Case file value must agree with the FIFO rules
    task automatic confirm_case(input int idx, input logic [11:0] file_v,
                                input logic [11:0] model_v);
        if (file_v !== model_v) begin
            abort_run($sformatf("case %0d expects %h but the FIFO model gives %h",
                                idx, file_v, model_v));
        end
    endtask

    // ==============================
    // Bus drivers
    // ==============================

    // Setup cycle then access cycle without wait states
    task automatic apb_write(input logic [3:0] addr, input logic [31:0] data,
                             output logic slverr);
        @(negedge tck);
        apb_req        = '0;
        apb_req.psel   = 1'b1;
        apb_req.pwrite = 1'b1;
        apb_req.paddr  = addr;
        apb_req.pwdata = data;
        @(negedge tck);
        apb_req.penable = 1'b1;
        // Registered response stays stable through the access cycle
        slverr = apb_rsp.pslverr;
        check_pready(apb_rsp.pready, 1'b1);
        @(negedge tck);
        apb_req = '0;
    endtask

    task automatic apb_read(input logic [3:0] addr, output logic [31:0] data,
                            output logic slverr);
        @(negedge tck);
        apb_req       = '0;
        apb_req.psel  = 1'b1;
        apb_req.paddr = addr;
        @(negedge tck);
        apb_req.penable = 1'b1;
        data   = apb_rsp.prdata;
        slverr = apb_rsp.pslverr;
        check_pready(apb_rsp.pready, 1'b1);
        @(negedge tck);
        apb_req = '0;
    endtask

    // One TAP edge without looking at tdo
    task automatic tap_step(input logic tms_v, input logic tdi_v);
        @(negedge tck);
        tms = tms_v;
        tdi = tdi_v;
        @(posedge tck);
    endtask

    // tdo read at the falling edge is the bit the next rising edge shifts out
    task automatic tap_shift(input logic tms_v, input logic tdi_v, output logic tdo_v);
        @(negedge tck);
        tdo_v = tdo;
        tms   = tms_v;
        tdi   = tdi_v;
        @(posedge tck);
    endtask

    // From Run-Test/Idle through an IR scan and back
    task automatic jtag_load_instruction(input logic [`JTAG_IR_LEN-1:0] code);
        logic [`JTAG_IR_LEN-1:0] captured;
        logic                    bit_out;
        captured = '0;
        tap_step(1'b1, 1'b0);
        tap_step(1'b1, 1'b0);
        tap_step(1'b0, 1'b0);
        tap_step(1'b0, 1'b0);
        // Last Shift-IR bit leaves on tms high
        for (int i = 0; i < `JTAG_IR_LEN; i++) begin
            tap_shift(i == `JTAG_IR_LEN - 1, code[i], bit_out);
            captured[i] = bit_out;
        end
        tap_step(1'b1, 1'b0);
        tap_step(1'b0, 1'b0);
        // Capture pattern leaves ahead of the new code
        check_ir_capture(captured, IR_CAPTURE);
    endtask

    task automatic jtag_select_user1();
        jtag_load_instruction(`JTAG_USER1);
        user1_active = 1'b1;
    endtask

    // Walks Capture-DR and n shifts through Update-DR back to Run-Test/Idle
    task automatic jtag_scan(input int n_shifts, input logic [SCAN_LEN-1:0] tdi_word,
                             output jtag_scan_t got);
        logic [SCAN_LEN-1:0] bits;
        logic                bit_out;
        bits = '0;
        tap_step(1'b1, 1'b0);
        tap_step(1'b0, 1'b0);
        if (n_shifts == 0) begin
            tap_step(1'b1, 1'b0);
        end else begin
            tap_step(1'b0, 1'b0);
            for (int i = 0; i < n_shifts; i++) begin
                tap_shift(i == n_shifts - 1, tdi_word[i], bit_out);
                bits[i] = bit_out;
            end
        end
        tap_step(1'b1, 1'b0);
        // Pop lands on this edge
        tap_step(1'b0, 1'b0);
        got = bits;
    endtask

    // ==============================
    // Checked operations
    // ==============================

    task automatic write_byte_checked(input logic [7:0] b);
        logic slverr;
        logic exp_err;
        exp_err = (model_q.size() == `TX_FIFO_DEPTH);
        apb_write(`UART_REG_DATA, {24'h0, b}, slverr);
        check_slverr(slverr, exp_err);
        if (!exp_err) begin
            model_q.push_back(b);
        end
    endtask

    // USER1 scan that compares only the shifted bits
    task automatic scan_checked(input int n_shifts);
        jtag_scan_t          got;
        jtag_scan_t          exp;
        logic [SCAN_LEN-1:0] mask;
        exp  = model_head();
        mask = (n_shifts >= SCAN_LEN) ? '1 : SCAN_LEN'((1 << n_shifts) - 1);
        jtag_scan(n_shifts, '0, got);
        check_scan(jtag_scan_t'(got & mask), jtag_scan_t'(exp & mask));
        // Complete scan of a valid word pops
        if (user1_active && (n_shifts >= SCAN_LEN) && (model_q.size() != 0)) begin
            void'(model_q.pop_front());
        end
    endtask

    // Random mix of writes and full scans
    task automatic run_burst(input int steps);
        for (int s = 0; s < steps; s++) begin
            rng_state = xorshift32(rng_state);
            if (rng_state[0]) begin
                write_byte_checked(rng_state[15:8]);
            end else begin
                scan_checked(SCAN_LEN);
            end
        end
    endtask

    // ==============================
    // Watchdog
    // ==============================

    initial begin
        int limit;
        wait (n_cases > 0);
        limit = 200 * n_cases + 2000;
        repeat (limit) @(posedge tck);
        abort_run($sformatf("watchdog expired after %0d tck cycles, the run hung", limit));
    end

    // ==============================
    // Case sequencer
    // ==============================

    initial begin
        int          loaded;
        logic [3:0]  op;
        logic [7:0]  operand;
        logic [11:0] expect_v;
        logic [31:0] rdata;
        logic        slverr;
        jtag_scan_t  got;
        jtag_scan_t  bypass_exp;

        tms          = 1'b1;
        tdi          = 1'b0;
        apb_req      = '0;
        reset_n      = 1'b0;
        user1_active = 1'b0;
        rng_state    = 32'd80886;

        $readmemh("testbench/jtag_uart_cases.txt", cases);
        loaded = 0;
        while ((loaded < MAX_CASES) && !$isunknown(cases[loaded])) begin
            loaded++;
        end
        if (loaded == 0) begin
            abort_run("no cases could be read from testbench/jtag_uart_cases.txt");
        end
        n_cases = loaded;

        repeat (4) @(posedge tck);
        @(negedge tck);
        reset_n = 1'b1;
        // Leave Test-Logic-Reset for Run-Test/Idle
        tap_step(1'b0, 1'b0);

        for (int idx = 0; idx < n_cases; idx++) begin
            op       = cases[idx][23:20];
            operand  = cases[idx][19:12];
            expect_v = cases[idx][11:0];
            case (op)
                OP_USER1: begin
                    jtag_select_user1();
                end
                OP_WRITE: begin
                    confirm_case(idx, expect_v, model_q.size() == `TX_FIFO_DEPTH);
                    write_byte_checked(operand);
                end
                OP_STATUS: begin
                    confirm_case(idx, expect_v, model_status());
                    apb_read(`UART_REG_STATUS, rdata, slverr);
                    check_slverr(slverr, 1'b0);
                    check_status(rdata[$bits(uart_status_t)-1:0], model_status());
                end
                OP_FLUSH: begin
                    apb_write(`UART_REG_CTRL, 32'h1, slverr);
                    check_slverr(slverr, 1'b0);
                    model_q.delete();
                end
                OP_SCAN: begin
                    confirm_case(idx, expect_v, model_head());
                    scan_checked(SCAN_LEN);
                end
                OP_SHORT: begin
                    confirm_case(idx, expect_v, model_head());
                    scan_checked(operand);
                end
                OP_BURST: begin
                    run_burst(operand);
                end
                OP_BYPASS: begin
                    jtag_load_instruction(`JTAG_BYPASS);
                    user1_active = 1'b0;
                    // Captured 0 leaves first and tdi follows one shift late
                    bypass_exp = {operand, 1'b0};
                    confirm_case(idx, expect_v, bypass_exp);
                    jtag_scan(SCAN_LEN, {1'b0, operand}, got);
                    check_scan(got, bypass_exp);
                end
                OP_FILL: begin
                    for (int i = 0; i < expect_v; i++) begin
                        write_byte_checked(operand + 8'(i));
                    end
                end
                default: begin
                    abort_run($sformatf("case %0d has unknown opcode %h", idx, op));
                end
            endcase
        end

        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== rtl/jtag_uart_top.sv ====
// JTAG UART top level
`timescale 1ns/100ps
`default_nettype none

module jtag_uart_top (
    input  logic                   tck,
    input  logic                   reset_n,
    input  logic                   tms,
    input  logic                   tdi,
    output logic                   tdo,
    input  jtag_uart_pkg::apb_req_t apb_req,
    output jtag_uart_pkg::apb_rsp_t apb_rsp
);
    import jtag_uart_pkg::*;

    tap_strobes_t strobes;
    logic         ir_tdo;
    logic         user1_sel;
    logic         scan_complete;
    logic         pop;
    logic         push;
    logic [7:0]   push_data;
    logic         flush;
    jtag_scan_t   head;
    uart_status_t status;

    // ==============================
    // TAP path
    // ==============================

    jtag_tap_controller tap_ctrl_i (
        .tck     (tck),
        .reset_n (reset_n),
        .tms     (tms),
        .state   (),
        .strobes (strobes)
    );

    jtag_instruction_register ir_i (
        .tck       (tck),
        .reset_n   (reset_n),
        .tdi       (tdi),
        .strobes   (strobes),
        .ir_tdo    (ir_tdo),
        .user1_sel (user1_sel)
    );

    shift_bit_counter shift_cnt_i (
        .tck           (tck),
        .reset_n       (reset_n),
        .strobes       (strobes),
        .scan_complete (scan_complete)
    );

    jtag_data_register dr_i (
        .tck           (tck),
        .reset_n       (reset_n),
        .tdi           (tdi),
        .strobes       (strobes),
        .user1_sel     (user1_sel),
        .scan_complete (scan_complete),
        .head          (head),
        .ir_tdo        (ir_tdo),
        .tdo           (tdo),
        .pop           (pop)
    );

    // ==============================
    // Buffer and bus slave
    // ==============================

    uart_tx_fifo fifo_i (
        .tck       (tck),
        .reset_n   (reset_n),
        .push      (push),
        .push_data (push_data),
        .pop       (pop),
        .flush     (flush),
        .head      (head),
        .status    (status)
    );

    apb_uart_regs regs_i (
        .tck       (tck),
        .reset_n   (reset_n),
        .apb_req   (apb_req),
        .apb_rsp   (apb_rsp),
        .status    (status),
        .push      (push),
        .push_data (push_data),
        .flush     (flush)
    );

endmodule

`default_nettype wire

// ==== rtl/apb_uart_regs.sv ====
// APB register block
`timescale 1ns/100ps
`default_nettype none

`include "jtag_uart_defines.svh"

module apb_uart_regs (
    input  logic                       tck,
    input  logic                       reset_n,
    input  jtag_uart_pkg::apb_req_t     apb_req,
    output jtag_uart_pkg::apb_rsp_t     apb_rsp,
    input  jtag_uart_pkg::uart_status_t status,
    output logic                       push,
    output logic [7:0]                 push_data,
    output logic                       flush
);
    import jtag_uart_pkg::*;

    apb_wdata_u wdata;
    logic       setup;
    logic       access;
    logic       hit_data;
    logic       hit_status;
    logic       hit_ctrl;
    logic       err_next;
    logic [31:0] rdata_next;
    logic [31:0] prdata_q;
    logic        pslverr_q;

    // ==============================
    // Decode
    // ==============================

    assign setup  = apb_req.psel & ~apb_req.penable;
    assign access = apb_req.psel & apb_req.penable;
    assign wdata  = apb_req.pwdata;

    assign hit_data   = (apb_req.paddr == `UART_REG_DATA);
    assign hit_status = (apb_req.paddr == `UART_REG_STATUS);
    assign hit_ctrl   = (apb_req.paddr == `UART_REG_CTRL);

    // Unknown offset, or a byte that has no room
    assign err_next = ~(hit_data | hit_status | hit_ctrl) |
                      (apb_req.pwrite & hit_data & status.full);

    // Only STATUS reads back, zero-extended
    assign rdata_next = (!apb_req.pwrite && hit_status) ? 32'(status) : '0;

    // ==============================
    // Response registers
    // ==============================

    // Loaded in setup so they are stable through the access cycle
    always_ff @(posedge tck or negedge reset_n) begin
        if (!reset_n) begin
            prdata_q  <= '0;
            pslverr_q <= 1'b0;
        end else if (setup) begin
            prdata_q  <= rdata_next;
            pslverr_q <= err_next;
        end else begin
            prdata_q  <= '0;
            pslverr_q <= 1'b0;
        end
    end

    // FIFO side, acts at the edge ending the access cycle
    // A byte flagged in setup stays refused even if a pop freed room
    assign push      = access & apb_req.pwrite & hit_data & ~pslverr_q;
    assign push_data = wdata.tx.tx_byte;
    assign flush     = access & apb_req.pwrite & hit_ctrl & wdata.ctrl.flush;

    // No wait states
    assign apb_rsp.prdata  = prdata_q;
    assign apb_rsp.pready  = 1'b1;
    assign apb_rsp.pslverr = pslverr_q;

endmodule

`default_nettype wire

// ==== rtl/uart_tx_fifo.sv ====
// Transmit byte FIFO
`timescale 1ns/100ps
`default_nettype none

`include "jtag_uart_defines.svh"

module uart_tx_fifo (
    input  logic                       tck,
    input  logic                       reset_n,
    input  logic                       push,
    input  logic [7:0]                 push_data,
    input  logic                       pop,
    input  logic                       flush,
    output jtag_uart_pkg::jtag_scan_t   head,
    output jtag_uart_pkg::uart_status_t status
);

    localparam int unsigned DEPTH  = `TX_FIFO_DEPTH;
    localparam int unsigned ADDR_W = $clog2(DEPTH);

    // Extra top bit tells full from empty
    logic [ADDR_W:0] wr_ptr;
    logic [ADDR_W:0] rd_ptr;
    logic [7:0]      mem [DEPTH];
    logic            empty;
    logic            full;
    logic            do_push;
    logic            do_pop;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]) &&
                   (wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);

    // Refused requests are dropped, flush wins
    assign do_push = push & ~full & ~flush;
    assign do_pop  = pop & ~empty & ~flush;

    always_ff @(posedge tck or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else if (flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Storage
    always_ff @(posedge tck) begin
        if (do_push) begin
            mem[wr_ptr[ADDR_W-1:0]] <= push_data;
        end
    end

    // Head word, all zero when nothing is queued
    always_comb begin
        head       = '0;
        head.valid = ~empty;
        if (!empty) begin
            head.data = mem[rd_ptr[ADDR_W-1:0]];
        end
    end

    // Pointer distance is the fill level
    assign status.count = wr_ptr - rd_ptr;
    assign status.full  = full;
    assign status.empty = empty;

endmodule

`default_nettype wire

// ==== rtl/jtag_data_register.sv ====
// USER1 and bypass data registers
`timescale 1ns/100ps
`default_nettype none

module jtag_data_register (
    input  logic                       tck,
    input  logic                       reset_n,
    input  logic                       tdi,
    input  jtag_uart_pkg::tap_strobes_t strobes,
    input  logic                       user1_sel,
    input  logic                       scan_complete,
    input  jtag_uart_pkg::jtag_scan_t   head,
    input  logic                       ir_tdo,
    output logic                       tdo,
    output logic                       pop
);
    import jtag_uart_pkg::*;

    jtag_scan_t dr_shift;
    logic       captured_valid;
    logic       bypass_bit;

    // ==============================
    // USER1 scan path
    // ==============================

    // Captured FIFO head shifting toward tdo
    always_ff @(posedge tck) begin
        if (strobes.capture_dr && user1_sel) begin
            dr_shift <= head;
        end else if (strobes.shift_dr && user1_sel) begin
            dr_shift <= {tdi, dr_shift[$bits(jtag_scan_t)-1:1]};
        end
    end

    // Valid flag of the word last captured
    always_ff @(posedge tck or negedge reset_n) begin
        if (!reset_n) begin
            captured_valid <= 1'b0;
        end else if (strobes.capture_dr) begin
            captured_valid <= user1_sel & head.valid;
        end
    end

    // ==============================
    // Bypass and tdo
    // ==============================

    always_ff @(posedge tck or negedge reset_n) begin
        if (!reset_n) begin
            bypass_bit <= 1'b0;
        end else if (strobes.capture_dr) begin
            bypass_bit <= 1'b0;
        end else if (strobes.shift_dr) begin
            bypass_bit <= tdi;
        end
    end

    // Pop on the edge leaving Update-DR
    assign pop = strobes.update_dr & user1_sel & captured_valid & scan_complete;

    // All sources are flops, so tdo moves only after a rising edge
    always_comb begin
        if (strobes.shift_ir) begin
            tdo = ir_tdo;
        end else if (user1_sel) begin
            tdo = dr_shift[0];
        end else begin
            tdo = bypass_bit;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/shift_bit_counter.sv ====
// Data register shift counter
`timescale 1ns/100ps
`default_nettype none

module shift_bit_counter (
    input  logic                       tck,
    input  logic                       reset_n,
    input  jtag_uart_pkg::tap_strobes_t strobes,
    output logic                       scan_complete
);
    import jtag_uart_pkg::*;

    // One shift per bit of the USER1 word
    localparam int unsigned SCAN_LEN = $bits(jtag_scan_t);
    localparam int unsigned CNT_W    = $clog2(SCAN_LEN + 1);
    localparam logic [CNT_W-1:0] SCAN_LAST = CNT_W'(SCAN_LEN);

    logic [CNT_W-1:0] shift_count;

    // Restart per capture, saturate at a full word
    always_ff @(posedge tck or negedge reset_n) begin
        if (!reset_n) begin
            shift_count <= '0;
        end else if (strobes.capture_dr) begin
            shift_count <= '0;
        end else if (strobes.shift_dr && (shift_count != SCAN_LAST)) begin
            shift_count <= shift_count + 1'b1;
        end
    end

    // Pause and resume still count, an early exit does not
    assign scan_complete = (shift_count == SCAN_LAST);

endmodule

`default_nettype wire

// ==== rtl/jtag_instruction_register.sv ====
// JTAG instruction register
`timescale 1ns/100ps
`default_nettype none

`include "jtag_uart_defines.svh"

module jtag_instruction_register (
    input  logic                       tck,
    input  logic                       reset_n,
    input  logic                       tdi,
    input  jtag_uart_pkg::tap_strobes_t strobes,
    output logic                       ir_tdo,
    output logic                       user1_sel
);

    logic [`JTAG_IR_LEN-1:0] ir_shift;
    logic [`JTAG_IR_LEN-1:0] ir_active;

    // Shift stage, LSB leaves first
    always_ff @(posedge tck or negedge reset_n) begin
        if (!reset_n) begin
            ir_shift <= '0;
        end else if (strobes.capture_ir) begin
            // Fixed capture pattern 1
            ir_shift <= `JTAG_IR_LEN'(1);
        end else if (strobes.shift_ir) begin
            ir_shift <= {tdi, ir_shift[`JTAG_IR_LEN-1:1]};
        end
    end

    // Update shadow, the instruction in force
    always_ff @(posedge tck or negedge reset_n) begin
        if (!reset_n) begin
            ir_active <= `JTAG_BYPASS;
        end else if (strobes.test_logic_reset) begin
            ir_active <= `JTAG_BYPASS;
        end else if (strobes.update_ir) begin
            ir_active <= ir_shift;
        end
    end

    assign ir_tdo    = ir_shift[0];
    assign user1_sel = (ir_active == `JTAG_USER1);

endmodule

`default_nettype wire

// ==== rtl/jtag_tap_controller.sv ====
// JTAG TAP state machine
`timescale 1ns/100ps
`default_nettype none

module jtag_tap_controller (
    input  logic                       tck,
    input  logic                       reset_n,
    input  logic                       tms,
    output jtag_uart_pkg::tap_state_e   state,
    output jtag_uart_pkg::tap_strobes_t strobes
);
    import jtag_uart_pkg::*;

    tap_state_e state_next;

    // ==============================
    // State register
    // ==============================

    always_ff @(posedge tck or negedge reset_n) begin
        if (!reset_n) begin
            state <= TEST_LOGIC_RESET;
        end else begin
            state <= state_next;
        end
    end

    // Standard 1149.1 graph, tms sampled at rising edge
    always_comb begin
        unique case (state)
            TEST_LOGIC_RESET: state_next = tms ? TEST_LOGIC_RESET : RUN_TEST_IDLE;
            RUN_TEST_IDLE:    state_next = tms ? SELECT_DR_SCAN : RUN_TEST_IDLE;
            SELECT_DR_SCAN:   state_next = tms ? SELECT_IR_SCAN : CAPTURE_DR;
            CAPTURE_DR:       state_next = tms ? EXIT1_DR : SHIFT_DR;
            SHIFT_DR:         state_next = tms ? EXIT1_DR : SHIFT_DR;
            EXIT1_DR:         state_next = tms ? UPDATE_DR : PAUSE_DR;
            PAUSE_DR:         state_next = tms ? EXIT2_DR : PAUSE_DR;
            EXIT2_DR:         state_next = tms ? UPDATE_DR : SHIFT_DR;
            UPDATE_DR:        state_next = tms ? SELECT_DR_SCAN : RUN_TEST_IDLE;
            SELECT_IR_SCAN:   state_next = tms ? TEST_LOGIC_RESET : CAPTURE_IR;
            CAPTURE_IR:       state_next = tms ? EXIT1_IR : SHIFT_IR;
            SHIFT_IR:         state_next = tms ? EXIT1_IR : SHIFT_IR;
            EXIT1_IR:         state_next = tms ? UPDATE_IR : PAUSE_IR;
            PAUSE_IR:         state_next = tms ? EXIT2_IR : PAUSE_IR;
            EXIT2_IR:         state_next = tms ? UPDATE_IR : SHIFT_IR;
            UPDATE_IR:        state_next = tms ? SELECT_DR_SCAN : RUN_TEST_IDLE;
            default:          state_next = TEST_LOGIC_RESET;
        endcase
    end

    // ==============================
    // Strobe decode
    // ==============================

    // Registers act on the edge that leaves the decoded state
    always_comb begin
        strobes                  = '0;
        strobes.capture_ir       = (state == CAPTURE_IR);
        strobes.shift_ir         = (state == SHIFT_IR);
        strobes.update_ir        = (state == UPDATE_IR);
        strobes.capture_dr       = (state == CAPTURE_DR);
        strobes.shift_dr         = (state == SHIFT_DR);
        strobes.update_dr        = (state == UPDATE_DR);
        // Held while parked, reloads the instruction
        strobes.test_logic_reset = (state == TEST_LOGIC_RESET);
    end

endmodule

`default_nettype wire

// ==== rtl/jtag_uart_pkg.sv ====
// JTAG UART shared types
`default_nettype none

`include "jtag_uart_defines.svh"

package jtag_uart_pkg;

    // IEEE 1149.1 controller states
    typedef enum logic [3:0] {
        TEST_LOGIC_RESET = 4'h0,
        RUN_TEST_IDLE    = 4'h1,
        SELECT_DR_SCAN   = 4'h2,
        CAPTURE_DR       = 4'h3,
        SHIFT_DR         = 4'h4,
        EXIT1_DR         = 4'h5,
        PAUSE_DR         = 4'h6,
        EXIT2_DR         = 4'h7,
        UPDATE_DR        = 4'h8,
        SELECT_IR_SCAN   = 4'h9,
        CAPTURE_IR       = 4'ha,
        SHIFT_IR         = 4'hb,
        EXIT1_IR         = 4'hc,
        PAUSE_IR         = 4'hd,
        EXIT2_IR         = 4'he,
        UPDATE_IR        = 4'hf
    } tap_state_e;

    // One-hot actions of the present state
    typedef struct packed {
        logic capture_ir;
        logic shift_ir;
        logic update_ir;
        logic capture_dr;
        logic shift_dr;
        logic update_dr;
        logic test_logic_reset;
    } tap_strobes_t;

    // FIFO fill level
    typedef struct packed {
        logic [$clog2(`TX_FIFO_DEPTH):0] count;
        logic                            full;
        logic                            empty;
    } uart_status_t;

    // USER1 scan word, valid shifts out first
    typedef struct packed {
        logic [7:0] data;
        logic       valid;
    } jtag_scan_t;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [3:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    // DATA register view
    typedef struct packed {
        logic [23:0] reserved;
        logic [7:0]  tx_byte;
    } apb_tx_view_t;

    // CTRL register view
    typedef struct packed {
        logic [30:0] reserved;
        logic        flush;
    } apb_ctrl_view_t;

    // Same write word, meaning picked by paddr
    typedef union packed {
        apb_tx_view_t   tx;
        apb_ctrl_view_t ctrl;
    } apb_wdata_u;

endpackage

`default_nettype wire

// ==== rtl/jtag_uart_defines.svh ====
// JTAG UART parameters
`ifndef JTAG_UART_DEFINES_SVH
`define JTAG_UART_DEFINES_SVH

// ==============================
// TAP instruction set
// ==============================

// Instruction register width
`define JTAG_IR_LEN 10

// Host-side UART channel
`define JTAG_USER1 10'h001

// Mandatory single-bit path
`define JTAG_BYPASS 10'h3ff

// ==============================
// Transmit buffer
// ==============================

// Entry count, power of two only
`define TX_FIFO_DEPTH 16

// APB byte offsets
`define UART_REG_DATA 4'h0
`define UART_REG_STATUS 4'h4
`define UART_REG_CTRL 4'h8

`endif
